//--- hdl/crop_pkg.sv
// shared types and constants for the blanking trim path; 12-bit coordinates, progressive only
package crop_pkg;

	typedef logic [11:0] coord_t;       // pixel or line position
	typedef logic [1:0]  res_t;         // core resolution flags
	typedef logic [6:0]  scr_flag_t;    // wraps at 128

	// one offset word, read raw or as a from-end flag with magnitude
	typedef union packed {
		coord_t raw;
		struct packed {
			logic        from_end;      // bottom offset counts back from the last line
			logic [10:0] magnitude;
		} rel;
	} trim_word_u;

	localparam logic [1:0] KBD_TYPE_KEY = 2'd3;

	localparam logic [7:0] KEY_BACKSPACE     = 8'h41;
	localparam logic [7:0] KEY_UP            = 8'h4c;
	localparam logic [7:0] KEY_DOWN          = 8'h4d;
	localparam logic [7:0] KEY_RIGHT         = 8'h4e;
	localparam logic [7:0] KEY_LEFT          = 8'h4f;
	localparam logic [7:0] KEY_ALT_L_PRESS   = 8'h64;
	localparam logic [7:0] KEY_ALT_R_PRESS   = 8'h65;
	localparam logic [7:0] KEY_ALT_L_RELEASE = 8'he4;
	localparam logic [7:0] KEY_ALT_R_RELEASE = 8'he5;

	localparam coord_t H_TRIM_STEP    = 12'd4;  // pixels per key press
	localparam coord_t V_TRIM_STEP    = 12'd1;  // lines per key press
	localparam coord_t H_FORCE_MARGIN = 12'd8;  // always blanked at each line end
	localparam coord_t BLANK_LEAD     = 12'd2;  // covers the output register delay

endpackage

//--- hdl/trim_if.sv
// four blanking offsets from the key control to the blank generators and snapshot, one clock
interface trim_if;
	import crop_pkg::*;

	trim_word_u hbl_l;  // left edge
	trim_word_u hbl_r;  // right edge
	trim_word_u vbl_t;  // top edge
	trim_word_u vbl_b;  // bottom edge, see from_end

	modport ctrl (output hbl_l, hbl_r, vbl_t, vbl_b);

	modport hgen (input hbl_l, hbl_r);

	modport vgen (input vbl_t, vbl_b);

	modport snap (input hbl_l, hbl_r, vbl_t, vbl_b);

endinterface

//--- hdl/crop_keys.sv
// key events are kbd_level toggles with type 3; preset_load overrides any key in the same cycle
module crop_keys (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [7:0]            kbd_data,
	input  logic [1:0]            kbd_type,
	input  logic                  kbd_level,
	input  logic                  preset_load,
	input  crop_pkg::trim_word_u  preset_hbl_l,
	input  crop_pkg::trim_word_u  preset_hbl_r,
	input  crop_pkg::trim_word_u  preset_vbl_t,
	input  crop_pkg::trim_word_u  preset_vbl_b,
	trim_if.ctrl                  trim
);
	import crop_pkg::*;

	logic       level_q;
	logic       key_vld;    // decoded event, one cycle behind the toggle
	logic [7:0] key_code;
	logic       alt;        // held alt moves the opposite edge

	always_ff @(posedge clk_sys)
		key_code <= kbd_data;

	// a key arriving together with a preset is dropped
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			level_q <= 1'b0;
			key_vld <= 1'b0;
		end else begin
			level_q <= kbd_level;
			key_vld <= (level_q ^ kbd_level) && (kbd_type == KBD_TYPE_KEY) && !preset_load;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			trim.hbl_l <= '0;
			trim.hbl_r <= '0;
			trim.vbl_t <= '0;
			trim.vbl_b <= '0;
			alt <= 1'b0;
		end else begin
			if (key_vld) begin
				case (key_code)
					KEY_BACKSPACE: begin
						trim.hbl_l <= '0;
						trim.hbl_r <= '0;
						trim.vbl_t <= '0;
						trim.vbl_b <= '0;
					end
					KEY_UP:
						if (alt) trim.vbl_b.raw <= trim.vbl_b.raw + V_TRIM_STEP;
						else     trim.vbl_t.raw <= trim.vbl_t.raw + V_TRIM_STEP;
					KEY_DOWN:
						if (alt) trim.vbl_b.raw <= trim.vbl_b.raw - V_TRIM_STEP;
						else     trim.vbl_t.raw <= trim.vbl_t.raw - V_TRIM_STEP;
					KEY_LEFT:
						if (alt) trim.hbl_r.raw <= trim.hbl_r.raw + H_TRIM_STEP;
						else     trim.hbl_l.raw <= trim.hbl_l.raw + H_TRIM_STEP;
					KEY_RIGHT:
						if (alt) trim.hbl_r.raw <= trim.hbl_r.raw - H_TRIM_STEP;
						else     trim.hbl_l.raw <= trim.hbl_l.raw - H_TRIM_STEP;
					KEY_ALT_L_PRESS, KEY_ALT_R_PRESS:     alt <= 1'b1;
					KEY_ALT_L_RELEASE, KEY_ALT_R_RELEASE: alt <= 1'b0;
					default: ;  // other keys ignored
				endcase
			end
			if (preset_load) begin  // last assignment wins
				trim.hbl_l <= preset_hbl_l;
				trim.hbl_r <= preset_hbl_r;
				trim.vbl_t <= preset_vbl_t;
				trim.vbl_b <= preset_vbl_b;
			end
		end
	end

	// offsets move two cycles after a key toggle or one cycle after a preset
	a_offsets_stable: assert property (@(posedge clk_sys) disable iff (reset)
		!$stable({trim.hbl_l, trim.hbl_r, trim.vbl_t, trim.vbl_b}) |->
			$past(preset_load) ||
			$past((level_q ^ kbd_level) && (kbd_type == KBD_TYPE_KEY), 2))
		else $error("trim offset changed without key or preset");

endmodule

//--- hdl/h_blank_gen.sv
// hs is active low; hsize is taken on row 1 only and trim offsets wrap as 12-bit values
module h_blank_gen (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              hs,
	input  logic              hblank,
	input  logic              vcnt_is_one,
	trim_if.hgen              trim,
	output logic              hbl,
	output crop_pkg::coord_t  hsize
);
	import crop_pkg::*;

	logic   old_hs;
	logic   old_hblank;
	logic   hs_fall;
	logic   hblank_fall;
	logic   hblank_rise;
	coord_t hcnt;   // pixel position in the line
	coord_t hend;   // first visible pixel
	coord_t hsta;   // first blank pixel after the visible part
	coord_t hmax;   // line length
	logic   shbl;   // trimmed blank
	logic   fhbl;   // forced edge blank

	assign hs_fall     = old_hs & ~hs;
	assign hblank_fall = old_hblank & ~hblank;
	assign hblank_rise = ~old_hblank & hblank;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs <= 1'b0;
			old_hblank <= 1'b0;
			hcnt <= '0;
			hend <= '0;
			hsta <= '0;
			hmax <= '0;
			shbl <= 1'b1;
			fhbl <= 1'b1;
			hsize <= '0;
		end else begin
			old_hs <= hs;
			old_hblank <= hblank;

			if (!hs)
				hcnt <= '0;  // held at zero through sync
			else
				hcnt <= hcnt + 12'd1;

			if (hblank_fall) hend <= hcnt;
			if (hblank_rise) hsta <= hcnt;
			if (hs_fall)     hmax <= hcnt;

			// trim edges advanced by the output register lead
			if (hcnt == hend + trim.hbl_l.raw - BLANK_LEAD) shbl <= 1'b0;
			if (hcnt == hsta + trim.hbl_r.raw - BLANK_LEAD) shbl <= 1'b1;

			if (hcnt == H_FORCE_MARGIN)        fhbl <= 1'b0;
			if (hcnt == hmax - H_FORCE_MARGIN) fhbl <= 1'b1;

			if (hblank_rise && vcnt_is_one)
				hsize <= hcnt - hend;
		end
	end

	assign hbl = shbl | fhbl | ~hs;

	// measured line must end its visible part after it starts
	a_hsize_order: assert property (@(posedge clk_sys) disable iff (reset)
		hblank_rise && vcnt_is_one |-> hcnt > hend)
		else $error("hblank rose before the visible part began on row 1");

endmodule

//--- hdl/v_blank_gen.sv
// vblank is the core vblank or vs low; every frame is treated as progressive
module v_blank_gen (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              hs,
	input  logic              vs,
	input  logic              vblank_in,
	input  logic              hbl,
	trim_if.vgen              trim,
	output logic              vcnt_is_one,
	output crop_pkg::coord_t  vsize,
	output logic              vblank_end,
	output logic              hde,
	output logic              vde
);
	import crop_pkg::*;

	logic   vblank;
	logic   old_vs;
	logic   old_hs;
	logic   old_vblank;
	logic   old_hbl;
	logic   vblank_fall;
	logic   vblank_rise;
	coord_t vcnt;       // line in the frame
	coord_t vend;       // first visible line
	coord_t vmax;       // last line before vblank
	coord_t vs_end;     // line where vsync ends
	coord_t top_line;
	coord_t bot_line;
	logic   svbl;       // trimmed blank
	logic   fvbl;       // forced blank around sync

	assign vblank      = vblank_in | ~vs;
	assign vblank_fall = old_vblank & ~vblank;
	assign vblank_rise = ~old_vblank & vblank;

	assign top_line = vend + trim.vbl_t.raw;
	// from_end adds the signed offset to the last line, else an absolute line
	assign bot_line = trim.vbl_b.rel.from_end ? coord_t'(vmax + trim.vbl_b.raw)
	                                          : {1'b0, trim.vbl_b.rel.magnitude};

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vs <= 1'b0;
			old_hs <= 1'b0;
			old_vblank <= 1'b0;
			old_hbl <= 1'b0;
			vcnt <= '0;
			vend <= '0;
			vmax <= '0;
			vs_end <= '0;
			vsize <= '0;
			vblank_end <= 1'b0;
			svbl <= 1'b1;
			fvbl <= 1'b1;
			hde <= 1'b0;
		end else begin
			old_vs <= vs;
			old_hs <= hs;
			old_vblank <= vblank;
			old_hbl <= hbl;
			vblank_end <= vblank_fall;  // one-cycle pulse for the snapshot

			if (old_hs && !hs) vcnt <= vcnt + 12'd1;
			if (vblank_rise)   vcnt <= '0;

			if (vblank_fall)  vend <= vcnt;
			if (!old_vs && vs) vs_end <= vcnt;
			if (vblank_rise) begin
				vmax <= vcnt;
				vsize <= vcnt - vend;
			end

			// edges move only at the start of a visible line
			if (old_hbl && !hbl) begin
				if (vcnt == top_line) svbl <= 1'b0;
				if (vcnt == bot_line) svbl <= 1'b1;

				if (vcnt == vmax - 12'd1)   fvbl <= 1'b1;
				if (vcnt == vs_end + 12'd2) fvbl <= 1'b0;
			end

			hde <= ~hbl;
		end
	end

	assign vcnt_is_one = (vcnt == 12'd1);
	assign vde = ~(svbl | fvbl);

endmodule

//--- hdl/screen_info.sv
// snapshot is taken on the vblank_end pulse; scr_flag wraps at 7 bits
module screen_info (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  vblank_end,
	input  crop_pkg::coord_t      hsize,
	input  crop_pkg::coord_t      vsize,
	input  crop_pkg::res_t        res,
	trim_if.snap                  trim,
	output crop_pkg::trim_word_u  scr_hbl_l,
	output crop_pkg::trim_word_u  scr_hbl_r,
	output crop_pkg::trim_word_u  scr_vbl_t,
	output crop_pkg::trim_word_u  scr_vbl_b,
	output crop_pkg::coord_t      scr_hsize,
	output crop_pkg::coord_t      scr_vsize,
	output crop_pkg::res_t        scr_res,
	output crop_pkg::scr_flag_t   scr_flag
);
	import crop_pkg::*;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			scr_hbl_l <= '0;
			scr_hbl_r <= '0;
			scr_vbl_t <= '0;
			scr_vbl_b <= '0;
			scr_hsize <= '0;
			scr_vsize <= '0;
			scr_res <= '0;
			scr_flag <= '0;
		end else if (vblank_end) begin
			scr_hbl_l <= trim.hbl_l;
			scr_hbl_r <= trim.hbl_r;
			scr_vbl_t <= trim.vbl_t;
			scr_vbl_b <= trim.vbl_b;
			scr_hsize <= hsize;
			scr_vsize <= vsize;
			scr_res <= res;
			// compared against the previous snapshot
			if (scr_res != res || scr_hsize != hsize || scr_vsize != vsize)
				scr_flag <= scr_flag + scr_flag_t'(1);
		end
	end

	// counter moves only with a vblank end snapshot that differs from the last
	a_flag_on_vbl_end: assert property (@(posedge clk_sys) disable iff (reset)
		!$stable(scr_flag) |-> $past(vblank_end) &&
			!$stable({scr_res, scr_hsize, scr_vsize}))
		else $error("scr_flag moved without a changed snapshot");

endmodule

//--- hdl/crop_top.sv
// single clock domain, no back-pressure; hs and vs active low as the core drives them
module crop_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  hs,
	input  logic                  vs,
	input  logic                  hblank,
	input  logic                  vblank,
	input  crop_pkg::res_t        res,
	input  logic [7:0]            kbd_data,
	input  logic [1:0]            kbd_type,
	input  logic                  kbd_level,
	input  logic                  preset_load,
	input  crop_pkg::trim_word_u  preset_hbl_l,
	input  crop_pkg::trim_word_u  preset_hbl_r,
	input  crop_pkg::trim_word_u  preset_vbl_t,
	input  crop_pkg::trim_word_u  preset_vbl_b,
	output logic                  hde,
	output logic                  vde,
	output crop_pkg::trim_word_u  scr_hbl_l,
	output crop_pkg::trim_word_u  scr_hbl_r,
	output crop_pkg::trim_word_u  scr_vbl_t,
	output crop_pkg::trim_word_u  scr_vbl_b,
	output crop_pkg::coord_t      scr_hsize,
	output crop_pkg::coord_t      scr_vsize,
	output crop_pkg::res_t        scr_res,
	output crop_pkg::scr_flag_t   scr_flag
);
	import crop_pkg::*;

	logic   hbl;            // combined horizontal blank
	logic   vcnt_is_one;
	logic   vblank_end;
	coord_t hsize;
	coord_t vsize;

	trim_if trim ();

	crop_keys u_keys (
		.clk_sys, .reset,
		.kbd_data, .kbd_type, .kbd_level,
		.preset_load,
		.preset_hbl_l, .preset_hbl_r, .preset_vbl_t, .preset_vbl_b,
		.trim (trim.ctrl)
	);

	h_blank_gen u_hgen (
		.clk_sys, .reset,
		.hs, .hblank, .vcnt_is_one,
		.trim (trim.hgen),
		.hbl, .hsize
	);

	v_blank_gen u_vgen (
		.clk_sys, .reset,
		.hs, .vs, .vblank_in (vblank), .hbl,
		.trim (trim.vgen),
		.vcnt_is_one, .vsize, .vblank_end, .hde, .vde
	);

	screen_info u_info (
		.clk_sys, .reset,
		.vblank_end, .hsize, .vsize, .res,
		.trim (trim.snap),
		.scr_hbl_l, .scr_hbl_r, .scr_vbl_t, .scr_vbl_b,
		.scr_hsize, .scr_vsize, .scr_res, .scr_flag
	);

endmodule

//--- tests/crop_tb.sv
// progressive synthetic video only, hsync 4 pixels wide; keys and presets are applied between frames
module crop_tb;
	import crop_pkg::*;

	logic clk_sys, reset, hs, vs, hblank, vblank, kbd_level, preset_load, hde, vde;
	logic [7:0] kbd_data;
	logic [1:0] kbd_type;
	res_t res, scr_res;
	trim_word_u preset_hbl_l, preset_hbl_r, preset_vbl_t, preset_vbl_b;
	trim_word_u scr_hbl_l, scr_hbl_r, scr_vbl_t, scr_vbl_b;
	coord_t scr_hsize, scr_vsize;
	scr_flag_t scr_flag, flag0;
	int errors, tests, err0, a, b, c, d, e, k;
	int hs_w = 4, hvs = 16, vvs = 5, hvis, htot, vvis, vtot;
	int meas_width, last_vde;
	trim_word_u tl, tr, tt, tb;

	crop_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (2000000) @(posedge clk_sys);
		$display("watchdog: run took too many cycles, stopping");
		$display("Finished with errors");
		$finish;
	end

	function automatic coord_t steps(int n_inc, int n_dec, coord_t step);
		return coord_t'(n_inc * step - n_dec * step);  // 12-bit wrap
	endfunction

	function automatic coord_t exp_width(int hv, trim_word_u l, trim_word_u r);
		return coord_t'(hv) + r.raw - l.raw;
	endfunction

	// last frame line with visible output, bounded by the forced blank
	function automatic coord_t exp_last_line(trim_word_u bot);
		coord_t vmax, bl, last;
		vmax = coord_t'(vtot - 1);
		bl = bot.rel.from_end ? vmax + bot.raw : {1'b0, bot.rel.magnitude};
		last = (bl - 12'd1 < vmax - 12'd2) ? bl - 12'd1 : vmax - 12'd2;
		return last - coord_t'(vtot - vvis) + coord_t'(vvs);
	endfunction

	function automatic scr_flag_t exp_flag(scr_flag_t start, int n_changes);
		return scr_flag_t'(start + n_changes);
	endfunction

	task automatic cmp_coord(coord_t got, coord_t exp, string what);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic cmp_trim(trim_word_u got, trim_word_u exp, string what);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic cmp_res(res_t got, res_t exp, string what);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic cmp_flag(scr_flag_t got, scr_flag_t exp, string what);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic end_test(string name);
		tests++;
		if (errors == err0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d mismatches", name, errors - err0);
		err0 = errors;
	endtask

	task automatic set_geom(int hv, int vv);
		hvis = hv;
		htot = hvs + hv + 16;
		vvis = vv;
		vtot = vvs + vv + 3;
	endtask

	// one frame; samples outputs before driving the next pixel
	task automatic gen_frame(int n = 1);
		int cnt;
		repeat (n) begin
			last_vde = -1;
			for (int l = 0; l < vtot; l++) begin
				cnt = 0;
				for (int p = 0; p < htot; p++) begin
					@(negedge clk_sys);
					if (hde) cnt++;
					if (hde && vde) last_vde = l;
					hs = (p >= hs_w);
					hblank = !(p >= hvs && p < hvs + hvis);
					vblank = !(l >= vvs && l < vvs + vvis);
					vs = (l >= 2);      // vsync on lines 0 and 1
				end
				if (l == vvs + 2) meas_width = cnt;
			end
		end
	endtask

	task automatic press_key(logic [7:0] code, int n = 1);
		repeat (n) begin
			@(negedge clk_sys);
			kbd_data = code;
			kbd_type = KBD_TYPE_KEY;
			kbd_level = ~kbd_level;
			repeat (3) @(negedge clk_sys);  // offset moves 2 cycles after the toggle
		end
	endtask

	task automatic load_preset(trim_word_u l, trim_word_u r, trim_word_u t, trim_word_u bt,
			bit with_key);
		@(negedge clk_sys);
		{preset_hbl_l, preset_hbl_r, preset_vbl_t, preset_vbl_b} = {l, r, t, bt};
		preset_load = 1'b1;
		if (with_key) begin
			kbd_data = KEY_LEFT;
			kbd_level = ~kbd_level;     // same cycle as the preset
		end
		@(negedge clk_sys);
		preset_load = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	initial begin
		{hs, vs, hblank, vblank} = 4'b1111;
		res = '0;
		kbd_data = '0;
		kbd_type = KBD_TYPE_KEY;
		kbd_level = 1'b0;
		preset_load = 1'b0;
		{preset_hbl_l, preset_hbl_r, preset_vbl_t, preset_vbl_b} = '0;
		errors = 0;
		tests = 0;
		err0 = 0;
		void'($urandom(32'h9820_06bb));
		reset = 1'b1;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		set_geom(20 + $urandom % 16, 10 + $urandom % 8);
		gen_frame(2);
		cmp_coord(scr_hsize, coord_t'(hvis), "scr_hsize");
		cmp_coord(scr_vsize, coord_t'(vvis), "scr_vsize");
		end_test("measurement");

		a = $urandom % 20;
		b = $urandom % 20;
		c = $urandom % 20;
		d = $urandom % 20;
		e = $urandom % 20;
		press_key(KEY_BACKSPACE);
		press_key(KEY_LEFT, a);
		press_key(KEY_RIGHT, b);
		press_key(KEY_ALT_L_PRESS);
		press_key(KEY_LEFT, c);
		press_key(KEY_DOWN, d);
		press_key(KEY_ALT_R_RELEASE);
		press_key(KEY_UP, e);
		gen_frame();
		cmp_trim(scr_hbl_l, steps(a, b, H_TRIM_STEP), "scr_hbl_l");
		cmp_trim(scr_hbl_r, steps(c, 0, H_TRIM_STEP), "scr_hbl_r");
		cmp_trim(scr_vbl_b, steps(0, d, V_TRIM_STEP), "scr_vbl_b");
		cmp_trim(scr_vbl_t, steps(e, 0, V_TRIM_STEP), "scr_vbl_t");
		press_key(KEY_BACKSPACE);
		gen_frame();
		cmp_trim(scr_hbl_l, '0, "cleared hbl_l");
		cmp_trim(scr_hbl_r, '0, "cleared hbl_r");
		cmp_trim(scr_vbl_t, '0, "cleared vbl_t");
		cmp_trim(scr_vbl_b, '0, "cleared vbl_b");
		end_test("key trim");

		tl = coord_t'(4 * ($urandom % 3));
		tr = coord_t'(4 * (int'($urandom % 4) - 2));  // -8 to 4
		load_preset(tl, tr, '0, '0, 1'b0);
		gen_frame(2);
		cmp_coord(coord_t'(meas_width), exp_width(hvis, tl, tr), "active width");
		end_test("active width");

		k = 2 + $urandom % 4;
		tb = coord_t'(-k);                              // from_end with -k
		load_preset('0, '0, '0, tb, 1'b0);
		gen_frame(2);
		cmp_coord(coord_t'(last_vde), exp_last_line(tb), "last line, from end");
		tb = coord_t'(vtot - vvis + 3 + $urandom % (vvis - 5));  // absolute line
		load_preset('0, '0, '0, tb, 1'b0);
		gen_frame(2);
		cmp_coord(coord_t'(last_vde), exp_last_line(tb), "last line, absolute");
		end_test("bottom offset");

		{tl, tr, tt, tb} = {12'($urandom), 12'($urandom), 12'($urandom), 12'($urandom)};
		load_preset(tl, tr, tt, tb, 1'b1);
		gen_frame();
		cmp_trim(scr_hbl_l, tl, "preset hbl_l");
		cmp_trim(scr_hbl_r, tr, "preset hbl_r");
		cmp_trim(scr_vbl_t, tt, "preset vbl_t");
		cmp_trim(scr_vbl_b, tb, "preset vbl_b");
		end_test("preset precedence");

		gen_frame(2);
		flag0 = scr_flag;
		gen_frame(3);
		cmp_flag(scr_flag, exp_flag(flag0, 0), "flag, same frames");
		res = res + 2'd1;
		gen_frame(3);
		cmp_flag(scr_flag, exp_flag(flag0, 1), "flag, res change");
		cmp_res(scr_res, res, "scr_res");
		set_geom(hvis + 4, vvis);
		gen_frame(3);
		cmp_flag(scr_flag, exp_flag(flag0, 2), "flag, width change");
		repeat (130) begin
			res = ~res;             // every snapshot differs
			gen_frame();
		end
		cmp_flag(scr_flag, exp_flag(flag0, 132), "flag after wrap");
		end_test("change counter");

		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- project.f
hdl/crop_pkg.sv
hdl/trim_if.sv
hdl/crop_keys.sv
hdl/h_blank_gen.sv
hdl/v_blank_gen.sv
hdl/screen_info.sv
hdl/crop_top.sv
tests/crop_tb.sv
